//--- files.f
+incdir+include
rtl/lc3b_types.sv
rtl/fetch_unit.sv
rtl/issue_control.sv
rtl/alu_reservation_station.sv
rtl/cdb_arbiter.sv
rtl/reorder_buffer.sv
rtl/regfile.sv
rtl/ooo_alu_core.sv
testbench/tb_ooo_alu_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary -f files.f --top-module tb_ooo_alu_core -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "Build or simulation run failed"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; } ||
{ echo "Simulation PASSED"; exit 0; }

//--- testbench/tb_ooo_alu_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_ooo_alu_core import lc3b_types::*; ();

localparam int num_instr = 200;
localparam int timeout_cycles = num_instr * 12;
localparam logic [31:0] seed = 32'h9716;

logic clk;
logic reset;
lc3b_word imem_rdata;
logic imem_resp;
logic imem_read;
lc3b_word imem_address;
logic commit_valid;
lc3b_reg commit_dest;
lc3b_word commit_value;

// Program image and reference model state
lc3b_word imem [num_instr];
lc3b_word model_regs [8];
int last_writer [8];
lc3b_reg exp_dest_q [$];
lc3b_word exp_value_q [$];
int kind_q [$];
bit dep_q [$];

logic [31:0] rng_state;
logic [15:0] delay_draw;
int resp_delay;
int fetch_idx;
int cycle_count;
logic timed_out;
int commit_count;
int checks;
int errors;
int errors_before;
// 0 register form, 1 negative immediate, 2 NOT, 3 dependent chain
int test_total [4];
int test_fails [4];

ooo_alu_core ooo_alu_core_i (.*);

always #10 clk = ~clk;

function automatic logic [15:0] next_random();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state[30:15];
endfunction

// Mostly r0..r3 so that instructions depend on each other
function automatic lc3b_reg pick_reg();
	logic [15:0] r;
	r = next_random();
	if (r[3:0] < 4'd12)
		return {1'b0, r[5:4]};
	else
		return r[6:4];
endfunction

task automatic generate_program();
	lc3b_reg dr, s1, s2;
	logic [4:0] imm5;
	logic [15:0] r;
	lc3b_word operand_b, result;
	int k, kind;
	bit imm_form, dep;
	for (int i = 0; i < 8; i++)
	begin
		model_regs[i] = 16'h0000;
		last_writer[i] = -10;
	end
	for (int i = 0; i < num_instr; i++)
	begin
		k = int'(next_random() % 16'd3);
		dr = pick_reg();
		s1 = pick_reg();
		s2 = pick_reg();
		r = next_random();
		imm_form = r[0];
		imm5 = r[5:1];
		if (r[6])
			imm5[4] = 1'b1;
		// Two's complement value of imm5 in a full word
		operand_b = imm_form ? (imm5[4] ? 16'(imm5) - 16'd32 : 16'(imm5)) : model_regs[s2];
		dep = (last_writer[s1] >= i - 2);
		if (k == 2)
		begin
			imem[i] = {4'b1001, dr, s1, 6'b111111};
			result = ~model_regs[s1];
			kind = 2;
		end
		else
		begin
			if (imm_form)
				imem[i] = {(k == 0) ? 4'b0001 : 4'b0101, dr, s1, 1'b1, imm5};
			else
			begin
				imem[i] = {(k == 0) ? 4'b0001 : 4'b0101, dr, s1, 3'b000, s2};
				dep = dep || (last_writer[s2] >= i - 2);
			end
			result = (k == 0) ? model_regs[s1] + operand_b : model_regs[s1] & operand_b;
			kind = !imm_form ? 0 : (imm5[4] ? 1 : -1);
		end
		model_regs[dr] = result;
		last_writer[dr] = i;
		exp_dest_q.push_back(dr);
		exp_value_q.push_back(result);
		kind_q.push_back(kind);
		dep_q.push_back(dep);
	end
endtask

task automatic check_reg(input lc3b_reg got, input lc3b_reg expected, input string what);
	checks++;
	if (got !== expected)
	begin
		$display("Mismatch at %0t: %s expected r%0d, got r%0d", $time, what, expected, got);
		errors++;
	end
endtask

task automatic check_word(input lc3b_word got, input lc3b_word expected, input string what);
	checks++;
	if (got !== expected)
	begin
		$display("Mismatch at %0t: %s expected %h, got %h", $time, what, expected, got);
		errors++;
	end
endtask

task automatic report_test(input int num, input string name, input int total, input int fails);
	$display("Test %0d %s: %0d commits checked, %0d failed", num, name, total, fails);
endtask

// Instruction memory with a random response delay per read
always @(posedge clk)
begin
	fetch_idx = int'(imem_address >> 1);
	if (reset)
	begin
		imem_resp <= 1'b0;
		resp_delay <= 0;
	end
	else if (imem_resp)
		imem_resp <= 1'b0;
	else if (imem_read && fetch_idx < num_instr)
	begin
		if (resp_delay == 0)
		begin
			imem_resp <= 1'b1;
			imem_rdata <= imem[fetch_idx];
			delay_draw = next_random();
			resp_delay <= int'(delay_draw[1:0]);
		end
		else
			resp_delay <= resp_delay - 1;
	end
end

always @(posedge clk)
begin
	if (reset)
	begin
		cycle_count <= 0;
		timed_out <= 1'b0;
	end
	else
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			timed_out <= 1'b1;
	end
end

// Every commit pops the model queue in program order
always @(posedge clk)
begin
	if (!reset && commit_valid)
	begin
		commit_count++;
		if (exp_dest_q.size() == 0)
		begin
			$display("Extra commit at %0t: more commits than instructions issued", $time);
			errors++;
		end
		else
		begin
			errors_before = errors;
			check_reg(commit_dest, exp_dest_q.pop_front(), "commit destination");
			check_word(commit_value, exp_value_q.pop_front(), "commit value");
			if (kind_q[0] >= 0)
			begin
				test_total[kind_q[0]]++;
				if (errors != errors_before)
					test_fails[kind_q[0]]++;
			end
			if (dep_q[0])
			begin
				test_total[3]++;
				if (errors != errors_before)
					test_fails[3]++;
			end
			void'(kind_q.pop_front());
			void'(dep_q.pop_front());
		end
	end
end

initial
begin
	clk = 1'b0;
	reset <= 1'b1;
	imem_resp <= 1'b0;
	imem_rdata <= 16'h0000;
	rng_state = seed;
	commit_count = 0;
	checks = 0;
	errors = 0;
	for (int i = 0; i < 4; i++)
	begin
		test_total[i] = 0;
		test_fails[i] = 0;
	end
	generate_program();
	repeat (4) @(posedge clk);
	reset <= 1'b0;
	while (commit_count < num_instr && !timed_out)
		@(posedge clk);
	// Catch any duplicate commit that trails the last one
	repeat (30) @(posedge clk);
	report_test(1, "register form ADD/AND", test_total[0], test_fails[0]);
	report_test(2, "negative immediate ADD/AND", test_total[1], test_fails[1]);
	report_test(3, "NOT", test_total[2], test_fails[2]);
	report_test(4, "dependent chains", test_total[3], test_fails[3]);
	$display("Test 5 commit count: %0d of %0d commits", commit_count, num_instr);
	if (timed_out)
		$display("Timeout: run stopped after %0d cycles with %0d of %0d commits",
			cycle_count, commit_count, num_instr);
	else if (commit_count != num_instr)
		$display("Commit count is wrong: %0d commits for %0d instructions",
			commit_count, num_instr);
	$display("Summary: %0d commits, %0d checks, %0d errors", commit_count, checks, errors);
	if (errors == 0 && !timed_out && commit_count == num_instr)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule : tb_ooo_alu_core

`default_nettype wire

//--- rtl/ooo_alu_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "lc3b_consts.svh"

module ooo_alu_core import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_word imem_rdata,
	input logic imem_resp,
	output logic imem_read,
	output lc3b_word imem_address,
	output logic commit_valid,
	output lc3b_reg commit_dest,
	output lc3b_word commit_value
);

// Fetch to issue
lc3b_word ir_out;
logic instr_valid, stall;

// Register file and ROB lookups
lc3b_reg sr1, sr2, reg_dest, rob_dest_in;
lc3b_word sr1_value, sr2_value, rob_sr1_value, rob_sr2_value;
logic sr1_busy, sr2_busy, rob_sr1_valid, rob_sr2_valid;
lc3b_rob_addr sr1_tag, sr2_tag, rob_sr1_read_addr, rob_sr2_read_addr;
lc3b_rob_addr rob_addr, reg_rob_entry, commit_tag;
logic rob_full, rob_write_enable, ld_busy;

// Station write bus and results
logic [`LC3B_NUM_ALU_RS-1:0] rs_busy, rs_write, rs_result_ready, rs_grant;
lc3b_rob_addr rs_result_tag [`LC3B_NUM_ALU_RS];
lc3b_word rs_result_value [`LC3B_NUM_ALU_RS];
lc3b_opcode res_op;
lc3b_word res_vj, res_vk;
lc3b_rob_addr res_qj, res_qk, res_dest;
logic res_vj_valid, res_vk_valid, res_imm_sel;

logic cdb_valid;
lc3b_rob_addr cdb_tag;
lc3b_word cdb_value;

fetch_unit fetch_unit_i (.*);

issue_control issue_control_i (.ir_in(ir_out), .*);

genvar g;
generate
	for (g = 0; g < `LC3B_NUM_ALU_RS; g++)
	begin : gen_alu_rs
		alu_reservation_station alu_rs_i
		(
			.clk, .reset,
			.write(rs_write[g]),
			.op(res_op), .vj(res_vj), .vk(res_vk), .qj(res_qj), .qk(res_qk),
			.vj_valid(res_vj_valid), .vk_valid(res_vk_valid),
			.dest(res_dest), .imm_sel(res_imm_sel),
			.cdb_valid, .cdb_tag, .cdb_value,
			.grant(rs_grant[g]),
			.busy(rs_busy[g]),
			.result_ready(rs_result_ready[g]),
			.result_tag(rs_result_tag[g]),
			.result_value(rs_result_value[g])
		);
	end
endgenerate

cdb_arbiter cdb_arbiter_i
(
	.clk, .reset,
	.result_ready(rs_result_ready), .result_tag(rs_result_tag),
	.result_value(rs_result_value), .grant(rs_grant),
	.cdb_valid, .cdb_tag, .cdb_value
);

reorder_buffer reorder_buffer_i
(
	.clk, .reset,
	.write_enable(rob_write_enable), .dest_in(rob_dest_in),
	.cdb_valid, .cdb_tag, .cdb_value,
	.sr1_read_addr(rob_sr1_read_addr), .sr2_read_addr(rob_sr2_read_addr),
	.w_addr_out(rob_addr), .full_out(rob_full),
	.sr1_valid_out(rob_sr1_valid), .sr2_valid_out(rob_sr2_valid),
	.sr1_value_out(rob_sr1_value), .sr2_value_out(rob_sr2_value),
	.commit_valid, .commit_dest, .commit_value, .commit_tag
);

regfile regfile_i (.rob_entry_in(reg_rob_entry), .*);

endmodule : ooo_alu_core

`default_nettype wire

//--- rtl/regfile.sv
`default_nettype none
`timescale 1ns/1ps

module regfile import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_reg sr1, sr2,
	input logic ld_busy,
	input lc3b_reg reg_dest,
	input lc3b_rob_addr rob_entry_in,
	input logic commit_valid,
	input lc3b_reg commit_dest,
	input lc3b_word commit_value,
	input lc3b_rob_addr commit_tag,
	output lc3b_word sr1_value, sr2_value,
	output logic sr1_busy, sr2_busy,
	output lc3b_rob_addr sr1_tag, sr2_tag
);

lc3b_word regs [8];
logic [7:0] busy;
lc3b_rob_addr tag [8];

assign sr1_value = regs[sr1];
assign sr2_value = regs[sr2];
assign sr1_busy = busy[sr1];
assign sr2_busy = busy[sr2];
assign sr1_tag = tag[sr1];
assign sr2_tag = tag[sr2];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < 8; i++)
		begin
			regs[i] <= '0;
			tag[i] <= '0;
		end
		busy <= '0;
	end
	else
	begin
		if (commit_valid)
		begin
			regs[commit_dest] <= commit_value;
			// Only the latest producer releases the register
			if (tag[commit_dest] == commit_tag)
				busy[commit_dest] <= 1'b0;
		end
		if (ld_busy)
		begin
			busy[reg_dest] <= 1'b1;
			tag[reg_dest] <= rob_entry_in;
		end
	end
end

endmodule : regfile

`default_nettype wire

//--- rtl/reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "lc3b_consts.svh"

module reorder_buffer import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic write_enable,
	input lc3b_reg dest_in,
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input lc3b_word cdb_value,
	input lc3b_rob_addr sr1_read_addr,
	input lc3b_rob_addr sr2_read_addr,
	output lc3b_rob_addr w_addr_out,
	output logic full_out,
	output logic sr1_valid_out,
	output logic sr2_valid_out,
	output lc3b_word sr1_value_out,
	output lc3b_word sr2_value_out,
	output logic commit_valid,
	output lc3b_reg commit_dest,
	output lc3b_word commit_value,
	output lc3b_rob_addr commit_tag
);

lc3b_reg dest_mem [`LC3B_ROB_DEPTH];
logic done_mem [`LC3B_ROB_DEPTH];
lc3b_word value_mem [`LC3B_ROB_DEPTH];

lc3b_rob_addr head, tail;
logic [`LC3B_ROB_ADDR_W:0] count;
logic retire;

assign w_addr_out = tail;
assign full_out = (count == `LC3B_ROB_DEPTH);
assign retire = (count != '0) && done_mem[head];

// Operand lookups for issue
assign sr1_valid_out = done_mem[sr1_read_addr];
assign sr2_valid_out = done_mem[sr2_read_addr];
assign sr1_value_out = value_mem[sr1_read_addr];
assign sr2_value_out = value_mem[sr2_read_addr];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		commit_valid <= 1'b0;
	end
	else
	begin
		commit_valid <= retire;
		if (write_enable)
			tail <= tail + 1'b1;
		if (retire)
			head <= head + 1'b1;
		if (write_enable && !retire)
			count <= count + 1'b1;
		else if (retire && !write_enable)
			count <= count - 1'b1;
	end
end

// A retired entry keeps its done bit until the slot is reused
always_ff @(posedge clk)
begin
	if (write_enable)
	begin
		dest_mem[tail] <= dest_in;
		done_mem[tail] <= 1'b0;
	end
	if (cdb_valid)
	begin
		done_mem[cdb_tag] <= 1'b1;
		value_mem[cdb_tag] <= cdb_value;
	end
	if (retire)
	begin
		commit_dest <= dest_mem[head];
		commit_value <= value_mem[head];
		commit_tag <= head;
	end
end

endmodule : reorder_buffer

`default_nettype wire

//--- rtl/cdb_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "lc3b_consts.svh"

module cdb_arbiter import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic [`LC3B_NUM_ALU_RS-1:0] result_ready,
	input lc3b_rob_addr result_tag [`LC3B_NUM_ALU_RS],
	input lc3b_word result_value [`LC3B_NUM_ALU_RS],
	output logic [`LC3B_NUM_ALU_RS-1:0] grant,
	output logic cdb_valid,
	output lc3b_rob_addr cdb_tag,
	output lc3b_word cdb_value
);

localparam int ptr_w = $clog2(`LC3B_NUM_ALU_RS + 1);

logic [ptr_w-1:0] ptr, cand, winner;

// Scan from the pointer and the first finished station wins
always_comb
begin
	cdb_valid = 1'b0;
	winner = ptr;
	cand = ptr;
	for (int i = 0; i < `LC3B_NUM_ALU_RS; i++)
	begin
		cand = ptr_w'((int'(ptr) + i) % `LC3B_NUM_ALU_RS);
		if (!cdb_valid && result_ready[cand])
		begin
			cdb_valid = 1'b1;
			winner = cand;
		end
	end
	grant = '0;
	grant[winner] = cdb_valid;
	cdb_tag = result_tag[winner];
	cdb_value = result_value[winner];
end

// Priority moves just past the last winner
always_ff @(posedge clk)
begin
	if (reset)
		ptr <= '0;
	else if (cdb_valid)
		ptr <= (int'(winner) == `LC3B_NUM_ALU_RS - 1) ? '0 : winner + 1'b1;
end

endmodule : cdb_arbiter

`default_nettype wire

//--- rtl/alu_reservation_station.sv
`default_nettype none
`timescale 1ns/1ps

module alu_reservation_station import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic write,
	input lc3b_opcode op,
	input lc3b_word vj, vk,
	input lc3b_rob_addr qj, qk,
	input logic vj_valid, vk_valid,
	input lc3b_rob_addr dest,
	input logic imm_sel,
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input lc3b_word cdb_value,
	input logic grant,
	output logic busy,
	output logic result_ready,
	output lc3b_rob_addr result_tag,
	output lc3b_word result_value
);

lc3b_opcode op_r;
lc3b_word vj_r, vk_r;
lc3b_rob_addr qj_r, qk_r;
logic vj_ok, vk_ok, imm_r;
logic snoop_j, snoop_k, compute;
lc3b_word alu_out;

// Wakeup on a matching broadcast
assign snoop_j = busy && !vj_ok && cdb_valid && cdb_tag == qj_r;
assign snoop_k = busy && !vk_ok && !imm_r && cdb_valid && cdb_tag == qk_r;
assign compute = busy && !result_ready && vj_ok && (vk_ok || imm_r);

always_comb
begin
	case (op_r)
		op_add: alu_out = vj_r + vk_r;
		op_and: alu_out = vj_r & vk_r;
		op_not: alu_out = ~vj_r;
		default: alu_out = vj_r;
	endcase
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		busy <= 1'b0;
		result_ready <= 1'b0;
		vj_ok <= 1'b0;
		vk_ok <= 1'b0;
	end
	else if (write)
	begin
		busy <= 1'b1;
		result_ready <= 1'b0;
		vj_ok <= vj_valid;
		vk_ok <= vk_valid;
	end
	else if (grant)
	begin
		// Result went out on the CDB so the station is free again
		busy <= 1'b0;
		result_ready <= 1'b0;
	end
	else
	begin
		if (snoop_j)
			vj_ok <= 1'b1;
		if (snoop_k)
			vk_ok <= 1'b1;
		if (compute)
			result_ready <= 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (write)
	begin
		op_r <= op;
		vj_r <= vj;
		vk_r <= vk;
		qj_r <= qj;
		qk_r <= qk;
		imm_r <= imm_sel;
		result_tag <= dest;
	end
	else
	begin
		if (snoop_j)
			vj_r <= cdb_value;
		if (snoop_k)
			vk_r <= cdb_value;
		if (compute)
			result_value <= alu_out;
	end
end

endmodule : alu_reservation_station

`default_nettype wire

//--- rtl/issue_control.sv
`default_nettype none
`timescale 1ns/1ps

`include "lc3b_consts.svh"

module issue_control import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_word ir_in,
	input logic instr_valid,
	output logic stall,
	output lc3b_reg sr1, sr2,
	input lc3b_word sr1_value, sr2_value,
	input logic sr1_busy, sr2_busy,
	input lc3b_rob_addr sr1_tag, sr2_tag,
	output lc3b_rob_addr rob_sr1_read_addr, rob_sr2_read_addr,
	input logic rob_sr1_valid, rob_sr2_valid,
	input lc3b_word rob_sr1_value, rob_sr2_value,
	input lc3b_rob_addr rob_addr,
	input logic rob_full,
	output logic rob_write_enable,
	output lc3b_reg rob_dest_in,
	input logic [`LC3B_NUM_ALU_RS-1:0] rs_busy,
	output logic [`LC3B_NUM_ALU_RS-1:0] rs_write,
	output lc3b_opcode res_op,
	output lc3b_word res_vj, res_vk,
	output lc3b_rob_addr res_qj, res_qk,
	output logic res_vj_valid, res_vk_valid,
	output lc3b_rob_addr res_dest,
	output logic res_imm_sel,
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input lc3b_word cdb_value,
	output logic ld_busy,
	output lc3b_reg reg_dest,
	output lc3b_rob_addr reg_rob_entry
);

issue_state_t state;
lc3b_word imm;
logic [`LC3B_NUM_ALU_RS-1:0] free_sel;
logic free_found;
logic dispatch;

assign res_op = lc3b_opcode'(ir_in[15:12]);
assign reg_dest = ir_in[11:9];
assign sr1 = ir_in[8:6];
assign sr2 = ir_in[2:0];
assign imm = {{11{ir_in[4]}}, ir_in[4:0]};
// NOT carries no second source
assign res_imm_sel = ir_in[5] || (res_op == op_not);

assign rob_sr1_read_addr = sr1_tag;
assign rob_sr2_read_addr = sr2_tag;

// Take the operand from the register file or a finished ROB entry or the CDB before the tag
always_comb
begin
	res_qj = sr1_tag;
	res_vj_valid = 1'b1;
	res_vj = sr1_value;
	if (sr1_busy && rob_sr1_valid)
		res_vj = rob_sr1_value;
	else if (sr1_busy && cdb_valid && cdb_tag == sr1_tag)
		res_vj = cdb_value;
	else if (sr1_busy)
		res_vj_valid = 1'b0;
end

always_comb
begin
	res_qk = sr2_tag;
	res_vk_valid = 1'b1;
	res_vk = sr2_value;
	if (res_imm_sel)
		res_vk = imm;
	else if (sr2_busy && rob_sr2_valid)
		res_vk = rob_sr2_value;
	else if (sr2_busy && cdb_valid && cdb_tag == sr2_tag)
		res_vk = cdb_value;
	else if (sr2_busy)
		res_vk_valid = 1'b0;
end

// Lowest numbered free station
always_comb
begin
	free_sel = '0;
	free_found = 1'b0;
	for (int i = 0; i < `LC3B_NUM_ALU_RS; i++)
	begin
		if (!free_found && !rs_busy[i])
		begin
			free_sel[i] = 1'b1;
			free_found = 1'b1;
		end
	end
end

assign dispatch = (state != idle) && free_found && !rob_full;
assign stall = !dispatch;

assign rs_write = dispatch ? free_sel : '0;
assign rob_write_enable = dispatch;
assign rob_dest_in = reg_dest;
assign res_dest = rob_addr;
assign ld_busy = dispatch;
assign reg_rob_entry = rob_addr;

always_ff @(posedge clk)
begin
	if (reset)
		state <= idle;
	else
	begin
		case (state)
			idle:
				if (instr_valid)
					state <= decode;
			decode:
				state <= dispatch ? idle : stalled;
			stalled:
				if (dispatch)
					state <= idle;
			default:
				state <= idle;
		endcase
	end
end

endmodule : issue_control

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_word imem_rdata,
	input logic imem_resp,
	input logic stall,
	output logic imem_read,
	output lc3b_word imem_address,
	output lc3b_word ir_out,
	output logic instr_valid
);

lc3b_word pc;

assign imem_address = pc;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		pc <= 16'h0000;
		imem_read <= 1'b0;
		instr_valid <= 1'b0;
	end
	else if (imem_read && imem_resp)
	begin
		pc <= pc + 16'd2;
		imem_read <= 1'b0;
		instr_valid <= 1'b1;
	end
	else if (instr_valid && !stall)
	begin
		// Issue took the word so go for the next one
		instr_valid <= 1'b0;
		imem_read <= 1'b1;
	end
	else if (!instr_valid && !imem_read)
		imem_read <= 1'b1;
end

// Held until issue consumes it
always_ff @(posedge clk)
begin
	if (imem_read && imem_resp)
		ir_out <= imem_rdata;
end

endmodule : fetch_unit

`default_nettype wire

//--- rtl/lc3b_types.sv
`default_nettype none

`include "lc3b_consts.svh"

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Reorder buffer entry number, doubles as the rename tag
	typedef logic [`LC3B_ROB_ADDR_W-1:0] lc3b_rob_addr;

	// Operate instructions only
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0]
	{
		idle,
		decode,
		stalled
	} issue_state_t;

endpackage : lc3b_types

`default_nettype wire

//--- include/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// ALU reservation stations behind the issue controller
`define LC3B_NUM_ALU_RS 3

// Reorder buffer entries as a power of two so the pointers wrap on their own
`define LC3B_ROB_DEPTH 8

// Tag width as log2 of the buffer depth
`define LC3B_ROB_ADDR_W 3

`endif
